// File: src/dmac_cfg_pkg.sv
package dmac_cfg_pkg;

  // ******************************
  // Sizes
  // ******************************

  // Port 0 is the cluster, port 1 the fabric controller
  localparam int NB_CTRLS        = 2;
  localparam int CTRL_ID_WIDTH   = $clog2(NB_CTRLS);

  localparam int DATA_WIDTH      = 32;
  localparam int TCDM_ADDR_WIDTH = 10;
  localparam int EXT_ADDR_WIDTH  = 16;
  localparam int LEN_WIDTH       = 8;

  // Command queue
  localparam int QUEUE_DEPTH     = 4;
  localparam int QPTR_WIDTH      = $clog2(QUEUE_DEPTH);
  localparam int QCNT_WIDTH      = $clog2(QUEUE_DEPTH + 1);

  // ******************************
  // Control register map
  // ******************************

  localparam int OFFS_WIDTH = 3;

  localparam logic [OFFS_WIDTH-1:0] REG_LEN       = 3'd0;
  localparam logic [OFFS_WIDTH-1:0] REG_TCDM_ADDR = 3'd1;
  localparam logic [OFFS_WIDTH-1:0] REG_EXT_ADDR  = 3'd2;
  // Write enqueues a command, wdata bit 0 is the opcode
  localparam logic [OFFS_WIDTH-1:0] REG_CMD       = 3'd3;
  // Read only: bit 0 busy, upper bits fill level
  localparam logic [OFFS_WIDTH-1:0] REG_STATUS    = 3'd4;

endpackage

// File: src/dmac_types_pkg.sv
package dmac_types_pkg;

  // ******************************
  // Scalar types
  // ******************************

  typedef logic [dmac_cfg_pkg::DATA_WIDTH-1:0]      word_t;
  typedef logic [dmac_cfg_pkg::LEN_WIDTH-1:0]       len_t;
  typedef logic [dmac_cfg_pkg::TCDM_ADDR_WIDTH-1:0] tcdm_addr_t;
  typedef logic [dmac_cfg_pkg::EXT_ADDR_WIDTH-1:0]  ext_addr_t;
  typedef logic [dmac_cfg_pkg::CTRL_ID_WIDTH-1:0]   ctrl_id_t;
  typedef logic [dmac_cfg_pkg::QPTR_WIDTH-1:0]      qptr_t;
  typedef logic [dmac_cfg_pkg::QCNT_WIDTH-1:0]      qcnt_t;

  // Direction of a transfer
  typedef enum logic {
    OPC_EXT2TCDM = 1'b0,
    OPC_TCDM2EXT = 1'b1
  } dma_opc_e;

  // ******************************
  // Bus and command traffic
  // ******************************

  typedef struct packed {
    logic                                req;
    logic                                we;
    logic [dmac_cfg_pkg::OFFS_WIDTH-1:0] offset;
    word_t                               wdata;
  } ctrl_req_t;

  typedef struct packed {
    logic  gnt;
    logic  r_valid;
    word_t r_rdata;
  } ctrl_rsp_t;

  // TCDM side only looks at the low address bits
  typedef struct packed {
    logic      req;
    logic      we;
    ext_addr_t addr;
    word_t     wdata;
  } mem_req_t;

  typedef struct packed {
    logic  gnt;
    logic  r_valid;
    word_t r_rdata;
  } mem_rsp_t;

  typedef struct packed {
    dma_opc_e   opc;
    len_t       len;
    tcdm_addr_t tcdm_addr;
    ext_addr_t  ext_addr;
    ctrl_id_t   ctrl_id;
  } dma_cmd_t;

  typedef enum logic [2:0] {
    IDLE,
    RD_REQ,
    RD_WAIT,
    WR_REQ,
    DONE
  } mover_state_e;

endpackage

// File: src/dmac_ctrl_unit.sv
module dmac_ctrl_unit (
  input  logic                                                   clk_i,
  input  logic                                                   arst_n_i,
  input  dmac_types_pkg::ctrl_req_t [dmac_cfg_pkg::NB_CTRLS-1:0] ctrl_req_i,
  output dmac_types_pkg::ctrl_rsp_t [dmac_cfg_pkg::NB_CTRLS-1:0] ctrl_rsp_o,
  output dmac_types_pkg::dma_cmd_t                               cmd_o,
  output logic                                                   cmd_valid_o,
  input  logic                                                   cmd_pop_i,
  input  logic                                                   mover_busy_i,
  output logic                                                   busy_o
);

  // Arbitration
  logic [dmac_cfg_pkg::NB_CTRLS-1:0] eligible;
  logic [dmac_cfg_pkg::NB_CTRLS-1:0] gnt;
  logic                              gnt_any;
  dmac_types_pkg::ctrl_id_t          rr_ptr_q;
  dmac_types_pkg::ctrl_id_t          win_id;
  int                                arb_idx;
  dmac_types_pkg::ctrl_req_t         sel_req;

  // Per controller staging registers
  dmac_types_pkg::len_t       len_q       [dmac_cfg_pkg::NB_CTRLS];
  dmac_types_pkg::tcdm_addr_t tcdm_addr_q [dmac_cfg_pkg::NB_CTRLS];
  dmac_types_pkg::ext_addr_t  ext_addr_q  [dmac_cfg_pkg::NB_CTRLS];

  // Command queue
  dmac_types_pkg::dma_cmd_t queue_q [dmac_cfg_pkg::QUEUE_DEPTH];
  dmac_types_pkg::dma_cmd_t new_cmd;
  dmac_types_pkg::qptr_t    wr_ptr_q;
  dmac_types_pkg::qptr_t    rd_ptr_q;
  dmac_types_pkg::qcnt_t    count_q;
  logic                     q_full;
  logic                     push;
  logic                     pop;

  // Read response
  logic [dmac_cfg_pkg::NB_CTRLS-1:0] rvalid_q;
  dmac_types_pkg::word_t             rdata_q;
  dmac_types_pkg::word_t             status;

  // ******************************
  // Round robin arbiter
  // ******************************

  // A command write waits while the queue is full
  always_comb begin
    for (int i = 0; i < dmac_cfg_pkg::NB_CTRLS; i++) begin
      eligible[i] = ctrl_req_i[i].req &&
                    !(ctrl_req_i[i].we && ctrl_req_i[i].offset == dmac_cfg_pkg::REG_CMD &&
                      q_full);
    end
  end

  always_comb begin
    win_id  = rr_ptr_q;
    gnt_any = 1'b0;
    gnt     = '0;
    for (int k = 0; k < dmac_cfg_pkg::NB_CTRLS; k++) begin
      arb_idx = (int'(rr_ptr_q) + k) % dmac_cfg_pkg::NB_CTRLS;
      if (!gnt_any && eligible[arb_idx]) begin
        gnt_any = 1'b1;
        win_id  = dmac_types_pkg::ctrl_id_t'(arb_idx);
      end
    end
    if (gnt_any) begin
      gnt[win_id] = 1'b1;
    end
  end

  assign sel_req = ctrl_req_i[win_id];
  assign push    = gnt_any && sel_req.we && (sel_req.offset == dmac_cfg_pkg::REG_CMD);
  assign pop     = cmd_pop_i && cmd_valid_o;
  assign q_full  = (count_q == dmac_types_pkg::qcnt_t'(dmac_cfg_pkg::QUEUE_DEPTH));

  // Command built from the winner's staging registers
  always_comb begin
    new_cmd.opc       = dmac_types_pkg::dma_opc_e'(sel_req.wdata[0]);
    new_cmd.len       = len_q[win_id];
    new_cmd.tcdm_addr = tcdm_addr_q[win_id];
    new_cmd.ext_addr  = ext_addr_q[win_id];
    new_cmd.ctrl_id   = win_id;
  end

  // ******************************
  // Control state
  // ******************************

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_ptr_q <= '0;
      rvalid_q <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      rvalid_q <= gnt;
      if (gnt_any) begin
        rr_ptr_q <= (win_id == dmac_types_pkg::ctrl_id_t'(dmac_cfg_pkg::NB_CTRLS - 1)) ?
                    '0 : win_id + 1'b1;
      end
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == dmac_types_pkg::qptr_t'(dmac_cfg_pkg::QUEUE_DEPTH - 1)) ?
                    '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == dmac_types_pkg::qptr_t'(dmac_cfg_pkg::QUEUE_DEPTH - 1)) ?
                    '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Staging writes, queue storage and read data
  always_ff @(posedge clk_i) begin
    if (gnt_any && sel_req.we) begin
      case (sel_req.offset)
        dmac_cfg_pkg::REG_LEN:       len_q[win_id]       <= sel_req.wdata[dmac_cfg_pkg::LEN_WIDTH-1:0];
        dmac_cfg_pkg::REG_TCDM_ADDR: tcdm_addr_q[win_id] <= sel_req.wdata[dmac_cfg_pkg::TCDM_ADDR_WIDTH-1:0];
        dmac_cfg_pkg::REG_EXT_ADDR:  ext_addr_q[win_id]  <= sel_req.wdata[dmac_cfg_pkg::EXT_ADDR_WIDTH-1:0];
        default: ;
      endcase
    end
    if (push) begin
      queue_q[wr_ptr_q] <= new_cmd;
    end
    if (gnt_any) begin
      rdata_q <= (!sel_req.we && sel_req.offset == dmac_cfg_pkg::REG_STATUS) ? status : '0;
    end
  end

  // ******************************
  // Outputs
  // ******************************

  always_comb begin
    status = '0;
    status[0] = busy_o;
    status[dmac_cfg_pkg::QCNT_WIDTH:1] = count_q;
  end

  always_comb begin
    for (int i = 0; i < dmac_cfg_pkg::NB_CTRLS; i++) begin
      ctrl_rsp_o[i].gnt     = gnt[i];
      ctrl_rsp_o[i].r_valid = rvalid_q[i];
      ctrl_rsp_o[i].r_rdata = rdata_q;
    end
  end

  assign cmd_o       = queue_q[rd_ptr_q];
  assign cmd_valid_o = (count_q != '0);
  assign busy_o      = cmd_valid_o || mover_busy_i;

endmodule

// File: src/dmac_word_mover.sv
module dmac_word_mover (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  dmac_types_pkg::dma_cmd_t          cmd_i,
  input  logic                              cmd_valid_i,
  output logic                              cmd_pop_o,
  output dmac_types_pkg::mem_req_t          tcdm_req_o,
  input  dmac_types_pkg::mem_rsp_t          tcdm_rsp_i,
  output dmac_types_pkg::mem_req_t          ext_req_o,
  input  dmac_types_pkg::mem_rsp_t          ext_rsp_i,
  output logic                              mover_busy_o,
  output logic [dmac_cfg_pkg::NB_CTRLS-1:0] term_evt_o
);

  dmac_types_pkg::mover_state_e state_q;
  dmac_types_pkg::mover_state_e state_d;

  // Current transfer
  dmac_types_pkg::dma_opc_e   opc_q;
  dmac_types_pkg::ctrl_id_t   ctrl_id_q;
  dmac_types_pkg::len_t       remaining_q;
  dmac_types_pkg::tcdm_addr_t tcdm_addr_q;
  dmac_types_pkg::ext_addr_t  ext_addr_q;
  dmac_types_pkg::word_t      data_q;

  // Source and destination views of the two ports
  dmac_types_pkg::mem_rsp_t src_rsp;
  dmac_types_pkg::mem_rsp_t dst_rsp;
  logic                     from_ext;
  logic                     last_word;
  logic                     rd_phase;
  logic                     wr_phase;
  logic                     wr_done;

  assign from_ext  = (opc_q == dmac_types_pkg::OPC_EXT2TCDM);
  assign src_rsp   = from_ext ? ext_rsp_i : tcdm_rsp_i;
  assign dst_rsp   = from_ext ? tcdm_rsp_i : ext_rsp_i;
  assign last_word = (remaining_q == dmac_types_pkg::len_t'(1));

  assign rd_phase = (state_q == dmac_types_pkg::RD_REQ);
  assign wr_phase = (state_q == dmac_types_pkg::WR_REQ);
  assign wr_done  = wr_phase && dst_rsp.gnt;

  // Head is taken as soon as the mover is idle
  assign cmd_pop_o    = (state_q == dmac_types_pkg::IDLE) && cmd_valid_i;
  assign mover_busy_o = (state_q != dmac_types_pkg::IDLE);

  // ******************************
  // FSM
  // ******************************

  always_comb begin
    state_d = state_q;
    case (state_q)
      dmac_types_pkg::IDLE: begin
        if (cmd_valid_i) begin
          // Zero length goes straight to the event
          state_d = (cmd_i.len == '0) ? dmac_types_pkg::DONE : dmac_types_pkg::RD_REQ;
        end
      end
      dmac_types_pkg::RD_REQ: begin
        if (src_rsp.gnt) begin
          state_d = dmac_types_pkg::RD_WAIT;
        end
      end
      dmac_types_pkg::RD_WAIT: begin
        if (src_rsp.r_valid) begin
          state_d = dmac_types_pkg::WR_REQ;
        end
      end
      dmac_types_pkg::WR_REQ: begin
        if (dst_rsp.gnt) begin
          state_d = last_word ? dmac_types_pkg::DONE : dmac_types_pkg::RD_REQ;
        end
      end
      dmac_types_pkg::DONE: begin
        state_d = dmac_types_pkg::IDLE;
      end
      default: begin
        state_d = dmac_types_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= dmac_types_pkg::IDLE;
      opc_q       <= dmac_types_pkg::OPC_EXT2TCDM;
      ctrl_id_q   <= '0;
      remaining_q <= '0;
    end else begin
      state_q <= state_d;
      if (cmd_pop_o) begin
        opc_q       <= cmd_i.opc;
        ctrl_id_q   <= cmd_i.ctrl_id;
        remaining_q <= cmd_i.len;
      end else if (wr_done) begin
        remaining_q <= remaining_q - 1'b1;
      end
    end
  end

  // ******************************
  // Data path
  // ******************************

  // Addresses only move after a destination grant, so they stay stable under req
  always_ff @(posedge clk_i) begin
    if (cmd_pop_o) begin
      tcdm_addr_q <= cmd_i.tcdm_addr;
      ext_addr_q  <= cmd_i.ext_addr;
    end else if (wr_done) begin
      tcdm_addr_q <= tcdm_addr_q + 1'b1;
      ext_addr_q  <= ext_addr_q + 1'b1;
    end
    if (state_q == dmac_types_pkg::RD_WAIT && src_rsp.r_valid) begin
      data_q <= src_rsp.r_rdata;
    end
  end

  always_comb begin
    tcdm_req_o       = '0;
    ext_req_o        = '0;
    tcdm_req_o.addr  = dmac_types_pkg::ext_addr_t'(tcdm_addr_q);
    tcdm_req_o.wdata = data_q;
    ext_req_o.addr   = ext_addr_q;
    ext_req_o.wdata  = data_q;
    if (from_ext) begin
      ext_req_o.req  = rd_phase;
      tcdm_req_o.req = wr_phase;
      tcdm_req_o.we  = wr_phase;
    end else begin
      tcdm_req_o.req = rd_phase;
      ext_req_o.req  = wr_phase;
      ext_req_o.we   = wr_phase;
    end
  end

  // One cycle pulse on the issuing controller's bit
  always_comb begin
    term_evt_o = '0;
    if (state_q == dmac_types_pkg::DONE) begin
      term_evt_o[ctrl_id_q] = 1'b1;
    end
  end

endmodule

// File: src/dmac_wrap.sv
module dmac_wrap (
  input  logic                                                   clk_i,
  input  logic                                                   arst_n_i,

  // Control ports, 0 cluster, 1 fabric controller
  input  dmac_types_pkg::ctrl_req_t [dmac_cfg_pkg::NB_CTRLS-1:0] ctrl_req_i,
  output dmac_types_pkg::ctrl_rsp_t [dmac_cfg_pkg::NB_CTRLS-1:0] ctrl_rsp_o,

  // TCDM port
  output dmac_types_pkg::mem_req_t                               tcdm_req_o,
  input  dmac_types_pkg::mem_rsp_t                               tcdm_rsp_i,

  // External memory port
  output dmac_types_pkg::mem_req_t                               ext_req_o,
  input  dmac_types_pkg::mem_rsp_t                               ext_rsp_i,

  output logic [dmac_cfg_pkg::NB_CTRLS-1:0]                      term_evt_o,
  output logic                                                   busy_o
);

  // Command hand-off between the two stages
  dmac_types_pkg::dma_cmd_t cmd;
  logic                     cmd_valid;
  logic                     cmd_pop;
  logic                     mover_busy;

  // ******************************
  // Control unit
  // ******************************

  dmac_ctrl_unit ctrl_unit_i (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .ctrl_req_i   ( ctrl_req_i ),
    .ctrl_rsp_o   ( ctrl_rsp_o ),
    .cmd_o        ( cmd        ),
    .cmd_valid_o  ( cmd_valid  ),
    .cmd_pop_i    ( cmd_pop    ),
    .mover_busy_i ( mover_busy ),
    .busy_o       ( busy_o     )
  );

  // ******************************
  // Word mover
  // ******************************

  dmac_word_mover word_mover_i (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .cmd_i        ( cmd        ),
    .cmd_valid_i  ( cmd_valid  ),
    .cmd_pop_o    ( cmd_pop    ),
    .tcdm_req_o   ( tcdm_req_o ),
    .tcdm_rsp_i   ( tcdm_rsp_i ),
    .ext_req_o    ( ext_req_o  ),
    .ext_rsp_i    ( ext_rsp_i  ),
    .mover_busy_o ( mover_busy ),
    .term_evt_o   ( term_evt_o )
  );

endmodule

// File: tb/dmac_assert.sv
module dmac_assert (
  input logic                                                   clk_i,
  input logic                                                   arst_n_i,
  input dmac_types_pkg::ctrl_req_t [dmac_cfg_pkg::NB_CTRLS-1:0] ctrl_req_i,
  input dmac_types_pkg::ctrl_rsp_t [dmac_cfg_pkg::NB_CTRLS-1:0] ctrl_rsp_o,
  input dmac_types_pkg::mem_req_t                               tcdm_req_o,
  input dmac_types_pkg::mem_rsp_t                               tcdm_rsp_i,
  input dmac_types_pkg::mem_req_t                               ext_req_o,
  input dmac_types_pkg::mem_rsp_t                               ext_rsp_i,
  input logic [dmac_cfg_pkg::NB_CTRLS-1:0]                      term_evt_o,
  input logic                                                   busy_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // ******************************
  // Handshakes
  // ******************************

  gnt_ctrl0: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ctrl_rsp_o[0].gnt |-> ctrl_req_i[0].req) else $error("ctrl 0 gnt without req");
  gnt_ctrl1: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ctrl_rsp_o[1].gnt |-> ctrl_req_i[1].req) else $error("ctrl 1 gnt without req");

  // Request fields stay put until granted
  hold_tcdm: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tcdm_req_o.req && !tcdm_rsp_i.gnt |=>
      tcdm_req_o.req && $stable(tcdm_req_o.addr) && $stable(tcdm_req_o.wdata))
    else $error("TCDM req dropped or changed before gnt");
  hold_ext: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ext_req_o.req && !ext_rsp_i.gnt |=>
      ext_req_o.req && $stable(ext_req_o.addr) && $stable(ext_req_o.wdata))
    else $error("ext req dropped or changed before gnt");

  // ******************************
  // Events and busy
  // ******************************

  evt_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    term_evt_o != '0 |=> term_evt_o == '0) else $error("term event longer than one cycle");

  // No memory traffic and no event while the subsystem reports idle
  idle_quiet: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !busy_o |-> !tcdm_req_o.req && !ext_req_o.req && term_evt_o == '0)
    else $error("memory req or term event while busy_o is low");

endmodule

bind dmac_wrap dmac_assert assert_i (
  .clk_i      ( clk_i      ),
  .arst_n_i   ( arst_n_i   ),
  .ctrl_req_i ( ctrl_req_i ),
  .ctrl_rsp_o ( ctrl_rsp_o ),
  .tcdm_req_o ( tcdm_req_o ),
  .tcdm_rsp_i ( tcdm_rsp_i ),
  .ext_req_o  ( ext_req_o  ),
  .ext_rsp_i  ( ext_rsp_i  ),
  .term_evt_o ( term_evt_o ),
  .busy_o     ( busy_o     )
);

// File: tb/tb_dmac.sv
module tb_dmac;
  timeunit 1ns;
  timeprecision 1ps;

  logic                                                   clk_i = 1'b0;
  logic                                                   arst_n_i;
  dmac_types_pkg::ctrl_req_t [dmac_cfg_pkg::NB_CTRLS-1:0] ctrl_req;
  dmac_types_pkg::ctrl_rsp_t [dmac_cfg_pkg::NB_CTRLS-1:0] ctrl_rsp;
  dmac_types_pkg::mem_req_t                               tcdm_req;
  dmac_types_pkg::mem_rsp_t                               tcdm_rsp;
  dmac_types_pkg::mem_req_t                               ext_req;
  dmac_types_pkg::mem_rsp_t                               ext_rsp;
  logic [dmac_cfg_pkg::NB_CTRLS-1:0]                      term_evt;
  logic                                                   busy;

  // Memory models and their shadow copies
  dmac_types_pkg::word_t tcdm_mem [1024];
  dmac_types_pkg::word_t ext_mem  [65536];
  dmac_types_pkg::word_t tcdm_ref [1024];
  dmac_types_pkg::word_t ext_ref  [65536];
  logic                  tcdm_allow;
  logic                  ext_allow;
  logic                  tcdm_rv;
  logic                  ext_rv;
  logic                  tcdm_pend;
  logic                  ext_pend;
  dmac_types_pkg::word_t tcdm_rd;
  dmac_types_pkg::word_t ext_rd;
  dmac_types_pkg::word_t tcdm_pdata;
  dmac_types_pkg::word_t ext_pdata;
  logic                  mem_stall;
  int                    acc_count;

  logic [31:0]           lcg_state = 32'd67724;
  int                    exp_ids [$];
  int                    evt_count;
  int                    stg_len [dmac_cfg_pkg::NB_CTRLS];
  int                    stg_t   [dmac_cfg_pkg::NB_CTRLS];
  int                    stg_e   [dmac_cfg_pkg::NB_CTRLS];
  int                    len3;
  int                    len4 [4];
  int                    len5 [6];
  int                    total_words;

  always #5 clk_i = ~clk_i;

  dmac_wrap DUT (
    .clk_i      ( clk_i    ),
    .arst_n_i   ( arst_n_i ),
    .ctrl_req_i ( ctrl_req ),
    .ctrl_rsp_o ( ctrl_rsp ),
    .tcdm_req_o ( tcdm_req ),
    .tcdm_rsp_i ( tcdm_rsp ),
    .ext_req_o  ( ext_req  ),
    .ext_rsp_i  ( ext_rsp  ),
    .term_evt_o ( term_evt ),
    .busy_o     ( busy     )
  );

  assign tcdm_rsp = '{gnt: tcdm_req.req & tcdm_allow, r_valid: tcdm_rv, r_rdata: tcdm_rd};
  assign ext_rsp  = '{gnt: ext_req.req & ext_allow, r_valid: ext_rv, r_rdata: ext_rd};

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Reference copy over the shadow arrays with addresses wrapping like the DUT counters
  function automatic void ref_copy(dmac_types_pkg::dma_opc_e opc, int len, int ta, int ea);
    for (int i = 0; i < len; i++) begin
      if (opc == dmac_types_pkg::OPC_EXT2TCDM) begin
        tcdm_ref[(ta + i) % 1024] = ext_ref[(ea + i) % 65536];
      end else begin
        ext_ref[(ea + i) % 65536] = tcdm_ref[(ta + i) % 1024];
      end
    end
  endfunction

  task automatic check_word(string name, dmac_types_pkg::word_t exp, dmac_types_pkg::word_t act);
    if (exp !== act) begin
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_evt(logic [dmac_cfg_pkg::NB_CTRLS-1:0] exp,
                           logic [dmac_cfg_pkg::NB_CTRLS-1:0] act);
    if (exp !== act) begin
      $display("Fail at %0t: term_evt_o expected %b got %b", $time, exp, act);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  // ******************************
  // Memory models
  // ******************************

  always @(negedge clk_i) begin : mem_model
    logic tg;
    logic eg;
    if (!arst_n_i) begin
      tcdm_rv = 1'b0;
      ext_rv = 1'b0;
      tcdm_pend = 1'b0;
      ext_pend = 1'b0;
      tcdm_allow = 1'b0;
      ext_allow = 1'b0;
    end else begin
      // Grant decision for the coming rising edge
      tcdm_allow = !mem_stall && (lcg_next() >> 16) % 4 != 0;
      ext_allow = !mem_stall && (lcg_next() >> 16) % 4 != 0;
      tg = tcdm_req.req && tcdm_allow;
      eg = ext_req.req && ext_allow;
      // Read data shows up in the cycle after the read grant
      tcdm_rv = tcdm_pend;
      tcdm_rd = tcdm_pdata;
      ext_rv = ext_pend;
      ext_rd = ext_pdata;
      tcdm_pend = tg && !tcdm_req.we;
      ext_pend = eg && !ext_req.we;
      if (tg && !tcdm_req.we) tcdm_pdata = tcdm_mem[tcdm_req.addr[9:0]];
      if (tg && tcdm_req.we) tcdm_mem[tcdm_req.addr[9:0]] = tcdm_req.wdata;
      if (eg && !ext_req.we) ext_pdata = ext_mem[ext_req.addr];
      if (eg && ext_req.we) ext_mem[ext_req.addr] = ext_req.wdata;
      acc_count += int'(tg) + int'(eg);
    end
  end

  // Events must arrive in queue order on the issuing controller's bit
  always @(negedge clk_i) begin : evt_checker
    int id;
    if (arst_n_i && term_evt !== '0) begin
      if (exp_ids.size() == 0) begin
        $display("Termination event at %0t with no command outstanding", $time);
        $display("TESTS FAILED");
        $fatal(1);
      end else begin
        id = exp_ids.pop_front();
        check_evt(2'(1 << id), term_evt);
        evt_count++;
      end
    end
  end

  // ******************************
  // Control port access
  // ******************************

  // Starts and ends on a falling edge; hold cycles expect a withheld grant first
  task automatic ctrl_access(int p, logic we, logic [2:0] offs, dmac_types_pkg::word_t wdata,
                             int hold, output dmac_types_pkg::word_t rdata);
    ctrl_req[p] = '{req: 1'b1, we: we, offset: offs, wdata: wdata};
    for (int i = 0; i < hold; i++) begin
      #1;
      if (ctrl_rsp[p].gnt) begin
        $display("Command write on port %0d granted at %0t with the queue full", p, $time);
        $display("TESTS FAILED");
        $fatal(1);
      end
      @(negedge clk_i);
    end
    if (hold > 0) mem_stall = 1'b0;
    forever begin
      #1;
      if (ctrl_rsp[p].gnt) break;
      @(negedge clk_i);
    end
    if (we) begin
      case (offs)
        dmac_cfg_pkg::REG_LEN:       stg_len[p] = int'(wdata[7:0]);
        dmac_cfg_pkg::REG_TCDM_ADDR: stg_t[p] = int'(wdata[9:0]);
        dmac_cfg_pkg::REG_EXT_ADDR:  stg_e[p] = int'(wdata[15:0]);
        dmac_cfg_pkg::REG_CMD: begin
          exp_ids.push_back(p);
          ref_copy(dmac_types_pkg::dma_opc_e'(wdata[0]), stg_len[p], stg_t[p], stg_e[p]);
        end
        default: ;
      endcase
    end
    @(posedge clk_i);
    @(negedge clk_i);
    ctrl_req[p].req = 1'b0;
    check_word($sformatf("ctrl_rsp_o[%0d].r_valid", p), 32'd1, 32'(ctrl_rsp[p].r_valid));
    rdata = ctrl_rsp[p].r_rdata;
  endtask

  task automatic issue_cmd(int p, dmac_types_pkg::dma_opc_e opc, int len, int ta, int ea,
                           int hold);
    dmac_types_pkg::word_t rd;
    ctrl_access(p, 1'b1, dmac_cfg_pkg::REG_LEN, 32'(len), 0, rd);
    ctrl_access(p, 1'b1, dmac_cfg_pkg::REG_TCDM_ADDR, 32'(ta), 0, rd);
    ctrl_access(p, 1'b1, dmac_cfg_pkg::REG_EXT_ADDR, 32'(ea), 0, rd);
    ctrl_access(p, 1'b1, dmac_cfg_pkg::REG_CMD, 32'(opc), hold, rd);
  endtask

  task automatic compare_mems();
    for (int i = 0; i < 1024; i++) begin
      check_word($sformatf("tcdm_mem[%0d]", i), tcdm_ref[i], tcdm_mem[i]);
    end
    for (int i = 0; i < 65536; i++) begin
      check_word($sformatf("ext_mem[%0d]", i), ext_ref[i], ext_mem[i]);
    end
  endtask

  // ******************************
  // Main sequence
  // ******************************

  initial begin : main
    dmac_types_pkg::word_t rd;
    int acc_before;
    arst_n_i = 1'b0;
    ctrl_req = '0;
    mem_stall = 1'b0;
    tcdm_allow = 1'b0;
    ext_allow = 1'b0;
    tcdm_rv = 1'b0;
    ext_rv = 1'b0;
    tcdm_rd = '0;
    ext_rd = '0;
    tcdm_pend = 1'b0;
    ext_pend = 1'b0;
    tcdm_pdata = '0;
    ext_pdata = '0;
    acc_count = 0;
    evt_count = 0;
    for (int i = 0; i < 1024; i++) begin
      tcdm_mem[i] = 32'hA500_0000 ^ (i * 32'h9E37_79B1);
      tcdm_ref[i] = tcdm_mem[i];
    end
    for (int i = 0; i < 65536; i++) begin
      ext_mem[i] = 32'h5A00_0000 ^ (i * 32'h0100_0193 + 32'h77);
      ext_ref[i] = ext_mem[i];
    end
    len3 = 1 + int'((lcg_next() >> 8) % 16);
    total_words = 8 + len3;
    foreach (len4[i]) begin
      len4[i] = 1 + int'((lcg_next() >> 8) % 8);
      total_words += len4[i];
    end
    foreach (len5[i]) begin
      len5[i] = 1 + int'((lcg_next() >> 8) % 8);
      total_words += len5[i];
    end

    fork
      begin : watchdog
        repeat (total_words * 40 + 2000) @(posedge clk_i);
        $display("The run timed out before all transfers finished");
        $display("TESTS FAILED");
        $fatal(1);
      end
    join_none

    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);

    // 1. Quiet after reset
    check_word("busy_o", 32'd0, 32'(busy));
    check_word("term_evt_o", 32'd0, 32'(term_evt));
    check_word("tcdm_req_o.req", 32'd0, 32'(tcdm_req.req));
    check_word("ext_req_o.req", 32'd0, 32'(ext_req.req));
    ctrl_access(0, 1'b0, dmac_cfg_pkg::REG_STATUS, '0, 0, rd);
    check_word("status", 32'd0, rd);

    // 2. Cluster copy from external memory
    issue_cmd(0, dmac_types_pkg::OPC_EXT2TCDM, 8, 16, 1000, 0);
    wait (evt_count == 1);
    @(negedge clk_i);
    compare_mems();

    // 3. Fabric copy to external memory
    issue_cmd(1, dmac_types_pkg::OPC_TCDM2EXT, len3, 200, 3000, 0);
    wait (evt_count == 2);
    @(negedge clk_i);
    compare_mems();

    // 4. Both controllers interleave their programming
    fork
      begin
        issue_cmd(0, dmac_types_pkg::OPC_EXT2TCDM, len4[0], 300, 5000, 0);
        issue_cmd(0, dmac_types_pkg::OPC_TCDM2EXT, len4[1], 320, 6000, 0);
      end
      begin
        issue_cmd(1, dmac_types_pkg::OPC_TCDM2EXT, len4[2], 400, 7000, 0);
        issue_cmd(1, dmac_types_pkg::OPC_EXT2TCDM, len4[3], 420, 8000, 0);
      end
    join
    wait (evt_count == 6);
    @(negedge clk_i);
    compare_mems();

    // 5. Back to back commands against a stalled memory fill the queue
    mem_stall = 1'b1;
    for (int i = 0; i < 5; i++) begin
      issue_cmd(i % 2, dmac_types_pkg::dma_opc_e'(i % 2), len5[i], 500 + 20 * i,
                9000 + 20 * i, 0);
    end
    issue_cmd(1, dmac_types_pkg::OPC_EXT2TCDM, len5[5], 700, 9500, 20);

    // 6. Status during activity
    ctrl_access(0, 1'b0, dmac_cfg_pkg::REG_STATUS, '0, 0, rd);
    check_word("status busy bit", 32'd1, rd & 32'd1);
    if (rd[31:1] > 31'd4) begin
      $display("Status fill level %0d exceeds the queue depth", rd[31:1]);
      $display("TESTS FAILED");
      $fatal(1);
    end
    wait (evt_count == 12);
    repeat (2) @(negedge clk_i);
    compare_mems();

    // Zero length command touches no memory
    acc_before = acc_count;
    issue_cmd(0, dmac_types_pkg::OPC_EXT2TCDM, 0, 0, 0, 0);
    wait (evt_count == 13);
    repeat (2) @(negedge clk_i);
    check_word("memory access count", 32'(acc_before), 32'(acc_count));

    check_word("busy_o", 32'd0, 32'(busy));
    ctrl_access(1, 1'b0, dmac_cfg_pkg::REG_STATUS, '0, 0, rd);
    check_word("status", 32'd0, rd);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: flist.f
src/dmac_cfg_pkg.sv
src/dmac_types_pkg.sv
src/dmac_ctrl_unit.sv
src/dmac_word_mover.sv
src/dmac_wrap.sv
tb/dmac_assert.sv
tb/tb_dmac.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_dmac
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
